//--- project.f
hw/riscv_pkg.sv
hw/alu.sv
hw/reg_file.sv
hw/fetch_stage.sv
hw/decoder.sv
hw/controller.sv
hw/csr.sv
hw/lsu.sv
hw/riscv_core.sv
testbench/clock_gen.sv
testbench/riscv_core_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    := --binary --timing --assert -Wno-fatal
TOP       := riscv_core_tb
FILELIST  := project.f
OBJDIR    := obj_dir
LOG       := sim.log

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(OBJDIR)/V$(TOP)

.PHONY: all run clean

all: run

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "TEST OK" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)

//--- testbench/core_patterns.hex
// Words 0 to 39: program image, one instruction per line
// Then store records: address data mask, ending with address FFFFFFFF
08400493
30549073
123450B7
67808093
FFD00113
401101B3
20302023
41C15213
001122B3
00524333
20602223
00000463
20202823
00001463
0080046F
20202823
00840667
20C02423
22102023
222000A3
22201123
22100683
22104703
22201783
22005803
22D02223
22F02423
23002623
00000073
00100073
00000000
20102003
10E02023
34202573
22A02823
341025F3
22B02A23
00458593
34159073
30200073
00000200 EDCBA985 0000000F
00000204 FFFFFFFE 0000000F
00000208 00000044 0000000F
00000220 12345678 0000000F
00000220 FDFDFDFD 00000002
00000220 FFFDFFFD 0000000C
00000224 FFFFFFFD 0000000F
00000228 FFFFFFFD 0000000F
0000022C 0000FD78 0000000F
00000230 0000000B 0000000F
00000234 00000070 0000000F
00000230 00000003 0000000F
00000234 00000074 0000000F
00000230 00000002 0000000F
00000234 00000078 0000000F
00000230 00000004 0000000F
00000234 0000007C 0000000F
00000100 000000FD 0000000F
FFFFFFFF 00000000 00000000

//--- testbench/riscv_core_tb.sv
module riscv_core_tb;

	timeunit 1ns;
	timeprecision 1ps;

	localparam int          PROG_WORDS      = 40;
	localparam int          REC_BASE        = 40;
	localparam int          CLK_PERIOD      = 100;
	localparam int          WATCHDOG_CYCLES = 40 * PROG_WORDS * 6;
	localparam logic [31:0] END_ADDR        = 32'h0000_0100;
	localparam logic [31:0] LIST_END        = 32'hFFFF_FFFF;

	logic        clk;
	logic        reset_i;
	logic        imem_valid_o;
	logic        imem_ready_i;
	logic [31:0] imem_addr_o;
	logic [31:0] imem_rdata_i;
	logic        dmem_valid_o;
	logic        dmem_ready_i;
	logic [31:0] dmem_addr_o;
	logic [31:0] dmem_wdata_o;
	logic [3:0]  dmem_we_o;
	logic [31:0] dmem_rdata_i;

	logic [31:0] patterns [0:255];
	logic [31:0] ram [0:1023];
	logic [31:0] rng_state;
	int          imem_wait;
	int          dmem_wait;
	bit          imem_active;
	bit          dmem_active;
	bit          dmem_stalled;
	logic [31:0] held_addr;
	logic [31:0] held_wdata;
	logic [3:0]  held_we;
	int          rec_idx;
	int          pass_count;
	int          fail_count;
	bit          run_done;

	clock_gen #(.PERIOD(CLK_PERIOD)) clock_gen (.clk_o(clk));

	riscv_core #(.BOOT_ADDR(32'h0000_0000)) UUT (
		.clk(clk), .reset_i(reset_i),
		.imem_valid_o(imem_valid_o), .imem_ready_i(imem_ready_i),
		.imem_addr_o(imem_addr_o), .imem_rdata_i(imem_rdata_i),
		.dmem_valid_o(dmem_valid_o), .dmem_ready_i(dmem_ready_i),
		.dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
		.dmem_we_o(dmem_we_o), .dmem_rdata_i(dmem_rdata_i)
	);

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	// Ready delay of 0 to 3 cycles
	function automatic int next_delay();
		rng_state = xorshift(rng_state);
		return int'(rng_state[1:0]);
	endfunction

	function automatic string test_group(input int idx);
		if (idx < 2)
			return "alu";
		else if (idx < 3)
			return "control";
		else if (idx < 9)
			return "subword";
		else if (idx < 17)
			return "trap";
		else
			return "final";
	endfunction

	task automatic check_store();
		logic [31:0] exp_addr;
		logic [31:0] exp_data;
		logic [3:0]  exp_mask;
		string       name;
		bit          ok;
		exp_addr = patterns[REC_BASE + 3 * rec_idx];
		exp_data = patterns[REC_BASE + 3 * rec_idx + 1];
		exp_mask = patterns[REC_BASE + 3 * rec_idx + 2][3:0];
		name     = $sformatf("store_%0d_%s", rec_idx, test_group(rec_idx));
		if (exp_addr == LIST_END)
		begin
			$display("error: store to %h after the last expected store", dmem_addr_o);
			fail_count++;
			return;
		end
		ok = 1'b1;
		assert (dmem_addr_o == exp_addr)
		else
		begin
			$display("mismatch %s addr: expected %h actual %h", name, exp_addr, dmem_addr_o);
			ok = 1'b0;
		end
		assert (dmem_wdata_o == exp_data)
		else
		begin
			$display("mismatch %s data: expected %h actual %h", name, exp_data, dmem_wdata_o);
			ok = 1'b0;
		end
		assert (dmem_we_o == exp_mask)
		else
		begin
			$display("mismatch %s mask: expected %h actual %h", name, exp_mask, dmem_we_o);
			ok = 1'b0;
		end
		if (ok)
			pass_count++;
		else
			fail_count++;
		$display("%s: %s", name, ok ? "pass" : "fail");
		rec_idx++;
	endtask

	task automatic serve_data();
		int word_idx;
		int b;
		dmem_ready_i = 1'b0;
		if (dmem_valid_o)
		begin
			// Request must hold while ready is low
			if (dmem_stalled)
			begin
				assert (dmem_addr_o == held_addr && dmem_wdata_o == held_wdata &&
					dmem_we_o == held_we)
				else
				begin
					$display("error: dmem request changed while waiting for ready");
					fail_count++;
				end
			end
			if (!dmem_active)
			begin
				dmem_active = 1'b1;
				dmem_wait   = next_delay();
			end
			if (dmem_wait == 0)
			begin
				dmem_ready_i = 1'b1;
				dmem_active  = 1'b0;
				dmem_stalled = 1'b0;
				word_idx     = int'(dmem_addr_o[11:2]);
				dmem_rdata_i = ram[word_idx];
				if (dmem_we_o != 4'b0000)
				begin
					check_store();
					for (b = 0; b < 4; b++)
						if (dmem_we_o[b])
							ram[word_idx][8 * b +: 8] = dmem_wdata_o[8 * b +: 8];
					if (dmem_addr_o == END_ADDR)
						run_done = 1'b1;
				end
			end
			else
			begin
				dmem_wait--;
				dmem_stalled = 1'b1;
				held_addr    = dmem_addr_o;
				held_wdata   = dmem_wdata_o;
				held_we      = dmem_we_o;
			end
		end
		else
		begin
			// Valid may not drop before ready
			assert (!dmem_stalled)
			else
			begin
				$display("error: dmem_valid_o dropped while waiting for ready");
				fail_count++;
			end
			dmem_active  = 1'b0;
			dmem_stalled = 1'b0;
		end
	endtask

	// Both memories answer on the falling edge
	always @(negedge clk)
	begin
		if (reset_i)
		begin
			imem_ready_i = 1'b0;
			dmem_ready_i = 1'b0;
			imem_active  = 1'b0;
			dmem_active  = 1'b0;
			dmem_stalled = 1'b0;
		end
		else
		begin
			imem_ready_i = 1'b0;
			if (imem_valid_o)
			begin
				if (!imem_active)
				begin
					imem_active = 1'b1;
					imem_wait   = next_delay();
				end
				if (imem_wait == 0)
				begin
					imem_ready_i = 1'b1;
					imem_active  = 1'b0;
					if (imem_addr_o[31:2] < PROG_WORDS)
						imem_rdata_i = patterns[imem_addr_o[9:2]];
					else
						imem_rdata_i = 32'h0000_0000;
				end
				else
				begin
					imem_wait--;
				end
			end
			serve_data();
		end
	end

	initial
	begin
		reset_i      = 1'b1;
		imem_ready_i = 1'b0;
		imem_rdata_i = 32'h0000_0000;
		dmem_ready_i = 1'b0;
		dmem_rdata_i = 32'h0000_0000;
		rng_state    = 32'h536b;
		rec_idx      = 0;
		pass_count   = 0;
		fail_count   = 0;
		run_done     = 1'b0;
		imem_wait    = 0;
		dmem_wait    = 0;
		$readmemh("testbench/core_patterns.hex", patterns);
		for (int i = 0; i < 1024; i++)
			ram[i] = 32'h5A5A_0000 ^ (32'(i) << 2) ^ (32'(i) << 18);

		repeat (10) @(posedge clk);
		@(negedge clk);
		reset_i = 1'b0;

		wait (run_done);
		// Let the final store handshake complete
		@(posedge clk);
		if (patterns[REC_BASE + 3 * rec_idx] != LIST_END)
		begin
			$display("error: run ended before store record %0d was seen", rec_idx);
			fail_count++;
		end
		$display("tests: %0d passed, %0d failed", pass_count, fail_count);
		if (fail_count == 0)
			$display("TEST OK");
		else
			$display("TEST FAILED");
		$finish;
	end

	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		$display("error: program did not finish within %0d cycles", WATCHDOG_CYCLES);
		$display("TEST FAILED");
		$finish;
	end

endmodule

//--- testbench/clock_gen.sv
module clock_gen #(
	parameter int PERIOD = 100
) (
	output logic clk_o
);

	timeunit 1ns;
	timeprecision 1ps;

	initial
	begin
		clk_o = 1'b0;
		forever
			#(PERIOD / 2) clk_o = ~clk_o;
	end

endmodule

//--- hw/riscv_core.sv
module riscv_core #(
	parameter riscv_pkg::addr_t BOOT_ADDR = 32'h0000_0000
) (
	input  logic             clk,
	input  logic             reset_i,

	output logic             imem_valid_o,
	input  logic             imem_ready_i,
	output riscv_pkg::addr_t imem_addr_o,
	input  riscv_pkg::word_t imem_rdata_i,

	output logic             dmem_valid_o,
	input  logic             dmem_ready_i,
	output riscv_pkg::addr_t dmem_addr_o,
	output riscv_pkg::word_t dmem_wdata_o,
	output logic [3:0]       dmem_we_o,
	input  riscv_pkg::word_t dmem_rdata_i
);

	import riscv_pkg::*;

	word_t     instr, imm, alu_operand_a, alu_operand_b, alu_result;
	addr_t     instr_addr, pc_plus4, target_addr, mtvec, mepc;
	logic      instr_valid;
	reg_addr_t rs1_addr, rs2_addr, rd_addr;
	word_t     rf_read_data_1, rf_read_data_2, rf_write_data;
	logic      rf_we, rf_we_allow;
	wb_sel_e   wb_sel;
	alu_op_e   alu_op;
	op_a_sel_e op_a_sel;
	op_b_sel_e op_b_sel;
	logic      load, store, load_signed;
	mem_size_e mem_size;
	csr_op_e   csr_op, csr_op_gated;
	csr_addr_t csr_addr;
	word_t     csr_rdata, lsu_rdata, trap_cause;
	logic      jump, branch, ecall, ebreak, mret, illegal;
	logic      retire, target_valid, trap, lsu_done, lsu_err;
	pc_sel_e   pc_sel;

	assign pc_plus4 = instr_addr + 32'd4;

	always_comb
	begin
		case (op_a_sel)
			OPA_IMM: alu_operand_a = imm;
			OPA_PC:  alu_operand_a = instr_addr;
			default: alu_operand_a = rf_read_data_1;
		endcase

		alu_operand_b = (op_b_sel == OPB_IMM) ? imm : rf_read_data_2;

		case (wb_sel)
			WB_LSU:  rf_write_data = lsu_rdata;
			WB_CSR:  rf_write_data = csr_rdata;
			WB_PC4:  rf_write_data = pc_plus4;
			default: rf_write_data = alu_result;
		endcase

		// Branches add their offset here since the ALU is busy comparing
		case (pc_sel)
			PC_BRANCH: target_addr = branch ? instr_addr + imm : {alu_result[31:1], 1'b0};
			PC_MEPC:   target_addr = mepc;
			default:   target_addr = mtvec;
		endcase
	end

	// CSR writes commit with the register write
	assign csr_op_gated = rf_we_allow ? csr_op : CSR_NONE;

	fetch_stage #(.BOOT_ADDR(BOOT_ADDR)) fetch_stage (
		.clk(clk), .reset_i(reset_i),
		.retire_i(retire), .target_valid_i(target_valid), .target_addr_i(target_addr),
		.instr_o(instr), .instr_addr_o(instr_addr), .instr_valid_o(instr_valid),
		.imem_valid_o(imem_valid_o), .imem_ready_i(imem_ready_i),
		.imem_addr_o(imem_addr_o), .imem_rdata_i(imem_rdata_i)
	);

	decoder decoder (
		.instr_i(instr),
		.rs1_addr_o(rs1_addr), .rs2_addr_o(rs2_addr), .rd_addr_o(rd_addr),
		.rf_we_o(rf_we), .wb_sel_o(wb_sel), .alu_op_o(alu_op),
		.op_a_sel_o(op_a_sel), .op_b_sel_o(op_b_sel), .imm_o(imm),
		.load_o(load), .store_o(store), .mem_size_o(mem_size), .load_signed_o(load_signed),
		.csr_op_o(csr_op), .csr_addr_o(csr_addr),
		.jump_o(jump), .branch_o(branch), .ecall_o(ecall), .ebreak_o(ebreak),
		.mret_o(mret), .illegal_o(illegal)
	);

	reg_file reg_file (
		.clk(clk), .reset_i(reset_i),
		.write_en_i(rf_we && rf_we_allow), .write_addr_i(rd_addr), .write_data_i(rf_write_data),
		.read_addr_1_i(rs1_addr), .read_addr_2_i(rs2_addr),
		.read_data_1_o(rf_read_data_1), .read_data_2_o(rf_read_data_2)
	);

	alu alu (
		.alu_op_i(alu_op), .operand_a_i(alu_operand_a), .operand_b_i(alu_operand_b),
		.alu_result_o(alu_result)
	);

	controller controller (
		.clk(clk), .reset_i(reset_i), .instr_valid_i(instr_valid),
		.jump_i(jump), .branch_i(branch), .ecall_i(ecall), .ebreak_i(ebreak),
		.mret_i(mret), .illegal_i(illegal), .load_i(load), .store_i(store),
		.lsu_done_i(lsu_done), .lsu_err_i(lsu_err), .comp_result_i(alu_result[0]),
		.mtvec_i(mtvec), .rf_we_allow_o(rf_we_allow), .retire_o(retire),
		.target_valid_o(target_valid), .pc_sel_o(pc_sel),
		.trap_o(trap), .trap_cause_o(trap_cause)
	);

	csr csr (
		.clk(clk), .reset_i(reset_i),
		.op_i(csr_op_gated), .addr_i(csr_addr), .wdata_i(rf_read_data_1), .rdata_o(csr_rdata),
		.trap_i(trap), .trap_cause_i(trap_cause), .pc_i(instr_addr),
		.mtvec_o(mtvec), .mepc_o(mepc)
	);

	lsu lsu (
		.clk(clk), .reset_i(reset_i),
		.load_i(load), .store_i(store), .instr_valid_i(instr_valid),
		.size_i(mem_size), .signed_i(load_signed),
		.addr_i(alu_result), .wdata_i(rf_read_data_2), .rdata_o(lsu_rdata),
		.done_o(lsu_done), .err_o(lsu_err),
		.dmem_valid_o(dmem_valid_o), .dmem_ready_i(dmem_ready_i),
		.dmem_addr_o(dmem_addr_o), .dmem_wdata_o(dmem_wdata_o),
		.dmem_we_o(dmem_we_o), .dmem_rdata_i(dmem_rdata_i)
	);

endmodule

//--- hw/lsu.sv
module lsu (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 load_i,
	input  logic                 store_i,
	input  logic                 instr_valid_i,
	input  riscv_pkg::mem_size_e size_i,
	input  logic                 signed_i,
	input  riscv_pkg::addr_t     addr_i,
	input  riscv_pkg::word_t     wdata_i,
	output riscv_pkg::word_t     rdata_o,
	output logic                 done_o,
	output logic                 err_o,
	output logic                 dmem_valid_o,
	input  logic                 dmem_ready_i,
	output riscv_pkg::addr_t     dmem_addr_o,
	output riscv_pkg::word_t     dmem_wdata_o,
	output logic [3:0]           dmem_we_o,
	input  riscv_pkg::word_t     dmem_rdata_i
);

	import riscv_pkg::*;

	typedef enum logic [1:0] {L_IDLE, L_BUSY, L_DONE} lsu_state_e;

	lsu_state_e state_q;
	logic       access;
	logic       misaligned;
	logic [3:0] mask;
	word_t      rdata_q;
	word_t      shifted;

	assign access = (load_i || store_i) && instr_valid_i;

	always_comb
	begin
		case (size_i)
			MEM_BYTE:
			begin
				misaligned   = 1'b0;
				mask         = 4'b0001 << addr_i[1:0];
				dmem_wdata_o = {4{wdata_i[7:0]}};
			end
			MEM_HALF:
			begin
				misaligned   = addr_i[0];
				mask         = 4'b0011 << {addr_i[1], 1'b0};
				dmem_wdata_o = {2{wdata_i[15:0]}};
			end
			default:
			begin
				misaligned   = addr_i[1:0] != 2'b00;
				mask         = 4'b1111;
				dmem_wdata_o = wdata_i;
			end
		endcase
	end

	assign err_o        = access && misaligned;
	assign dmem_valid_o = (state_q == L_IDLE && access && !misaligned) || state_q == L_BUSY;
	assign dmem_addr_o  = {addr_i[31:2], 2'b00};
	assign dmem_we_o    = store_i ? mask : 4'b0000;
	assign done_o       = state_q == L_DONE;

	always_ff @(posedge clk)
	begin
		if (reset_i)
			state_q <= L_IDLE;
		else
		begin
			case (state_q)
				L_IDLE:
					if (dmem_valid_o)
						state_q <= dmem_ready_i ? L_DONE : L_BUSY;
				L_BUSY:
					if (dmem_ready_i)
						state_q <= L_DONE;
				default: state_q <= L_IDLE;
			endcase
		end
	end

	always_ff @(posedge clk)
	begin
		if (dmem_valid_o && dmem_ready_i && load_i)
			rdata_q <= dmem_rdata_i;
	end

	// Lane select, then extend
	assign shifted = rdata_q >> {addr_i[1:0], 3'b000};

	always_comb
	begin
		case (size_i)
			MEM_BYTE: rdata_o = {{24{signed_i && shifted[7]}}, shifted[7:0]};
			MEM_HALF: rdata_o = {{16{signed_i && shifted[15]}}, shifted[15:0]};
			default:  rdata_o = rdata_q;
		endcase
	end

	done_err_excl: assert property (@(posedge clk) disable iff (reset_i)
		!(done_o && err_o));

endmodule

//--- hw/csr.sv
module csr (
	input  logic                 clk,
	input  logic                 reset_i,
	input  riscv_pkg::csr_op_e   op_i,
	input  riscv_pkg::csr_addr_t addr_i,
	input  riscv_pkg::word_t     wdata_i,
	output riscv_pkg::word_t     rdata_o,
	input  logic                 trap_i,
	input  riscv_pkg::word_t     trap_cause_i,
	input  riscv_pkg::addr_t     pc_i,
	output riscv_pkg::addr_t     mtvec_o,
	output riscv_pkg::addr_t     mepc_o
);

	import riscv_pkg::*;

	addr_t mtvec_q;
	addr_t mepc_q;
	word_t mcause_q;
	word_t wr_val;

	always_comb
	begin
		case (addr_i)
			CSR_MTVEC:  rdata_o = mtvec_q;
			CSR_MEPC:   rdata_o = mepc_q;
			CSR_MCAUSE: rdata_o = mcause_q;
			default:    rdata_o = '0;
		endcase
	end

	assign wr_val = (op_i == CSR_SET) ? (rdata_o | wdata_i) : wdata_i;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			mtvec_q  <= '0;
			mepc_q   <= '0;
			mcause_q <= '0;
		end
		else if (trap_i)
		begin
			mepc_q   <= pc_i;
			mcause_q <= trap_cause_i;
		end
		else if (op_i != CSR_NONE)
		begin
			case (addr_i)
				CSR_MTVEC:  mtvec_q  <= wr_val;
				CSR_MEPC:   mepc_q   <= wr_val;
				CSR_MCAUSE: mcause_q <= wr_val;
				default:    mcause_q <= mcause_q;
			endcase
		end
	end

	assign mtvec_o = mtvec_q;
	assign mepc_o  = mepc_q;

endmodule

//--- hw/controller.sv
module controller (
	input  logic               clk,
	input  logic               reset_i,
	input  logic               instr_valid_i,
	input  logic               jump_i,
	input  logic               branch_i,
	input  logic               ecall_i,
	input  logic               ebreak_i,
	input  logic               mret_i,
	input  logic               illegal_i,
	input  logic               load_i,
	input  logic               store_i,
	input  logic               lsu_done_i,
	input  logic               lsu_err_i,
	input  logic               comp_result_i,
	input  riscv_pkg::addr_t   mtvec_i,
	output logic               rf_we_allow_o,
	output logic               retire_o,
	output logic               target_valid_o,
	output riscv_pkg::pc_sel_e pc_sel_o,
	output logic               trap_o,
	output riscv_pkg::word_t   trap_cause_o
);

	import riscv_pkg::*;

	typedef enum logic [1:0] {EXEC, MEM_WAIT, DONE} ctrl_state_e;

	ctrl_state_e state_q, state_d;
	logic        exception;

	assign exception = illegal_i || ecall_i || ebreak_i || lsu_err_i;

	always_comb
	begin
		if (illegal_i)
			trap_cause_o = CAUSE_ILLEGAL;
		else if (ebreak_i)
			trap_cause_o = CAUSE_BREAK;
		else if (ecall_i)
			trap_cause_o = CAUSE_ECALL;
		else if (store_i)
			trap_cause_o = CAUSE_STORE_MISALIGN;
		else
			trap_cause_o = CAUSE_LOAD_MISALIGN;
	end

	always_comb
	begin
		state_d        = state_q;
		rf_we_allow_o  = 1'b0;
		retire_o       = 1'b0;
		target_valid_o = 1'b0;
		trap_o         = 1'b0;
		pc_sel_o       = PC_BRANCH;

		case (state_q)
			EXEC:
				if (instr_valid_i)
				begin
					if (exception)
					begin
						trap_o         = 1'b1;
						retire_o       = 1'b1;
						target_valid_o = 1'b1;
						pc_sel_o       = PC_TRAP;
						state_d        = DONE;
					end
					else if (load_i || store_i)
					begin
						state_d = MEM_WAIT;
					end
					else
					begin
						retire_o       = 1'b1;
						rf_we_allow_o  = 1'b1;
						target_valid_o = jump_i || mret_i || (branch_i && comp_result_i);
						pc_sel_o       = mret_i ? PC_MEPC : PC_BRANCH;
						state_d        = DONE;
					end
				end
			MEM_WAIT:
				if (lsu_done_i)
				begin
					retire_o      = 1'b1;
					rf_we_allow_o = 1'b1;
					state_d       = DONE;
				end
			// Hold until fetch drops the retired word
			DONE:
				if (!instr_valid_i)
					state_d = EXEC;
			default: state_d = EXEC;
		endcase
	end

	always_ff @(posedge clk)
	begin
		if (reset_i)
			state_q <= EXEC;
		else
			state_q <= state_d;
	end

	retire_valid: assert property (@(posedge clk) disable iff (reset_i)
		retire_o |-> instr_valid_i);

	// Handler set up by software before the first trap
	trap_vector: assert property (@(posedge clk) disable iff (reset_i)
		trap_o |-> mtvec_i[1:0] == 2'b00);

endmodule

//--- hw/decoder.sv
module decoder (
	input  riscv_pkg::word_t      instr_i,
	output riscv_pkg::reg_addr_t  rs1_addr_o,
	output riscv_pkg::reg_addr_t  rs2_addr_o,
	output riscv_pkg::reg_addr_t  rd_addr_o,
	output logic                  rf_we_o,
	output riscv_pkg::wb_sel_e    wb_sel_o,
	output riscv_pkg::alu_op_e    alu_op_o,
	output riscv_pkg::op_a_sel_e  op_a_sel_o,
	output riscv_pkg::op_b_sel_e  op_b_sel_o,
	output riscv_pkg::word_t      imm_o,
	output logic                  load_o,
	output logic                  store_o,
	output riscv_pkg::mem_size_e  mem_size_o,
	output logic                  load_signed_o,
	output riscv_pkg::csr_op_e    csr_op_o,
	output riscv_pkg::csr_addr_t  csr_addr_o,
	output logic                  jump_o,
	output logic                  branch_o,
	output logic                  ecall_o,
	output logic                  ebreak_o,
	output logic                  mret_o,
	output logic                  illegal_o
);

	import riscv_pkg::*;

	logic [6:0] opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;
	word_t      imm_i, imm_s, imm_b, imm_u, imm_j;

	function automatic alu_op_e arith_op(input logic [2:0] f3, input logic alt);
		case (f3)
			3'b000:  arith_op = alt ? ALU_SUB : ALU_ADD;
			3'b001:  arith_op = ALU_SLL;
			3'b010:  arith_op = ALU_SLT;
			3'b011:  arith_op = ALU_SLTU;
			3'b100:  arith_op = ALU_XOR;
			3'b101:  arith_op = alt ? ALU_SRA : ALU_SRL;
			3'b110:  arith_op = ALU_OR;
			default: arith_op = ALU_AND;
		endcase
	endfunction

	assign opcode = instr_i[6:0];
	assign funct3 = instr_i[14:12];
	assign funct7 = instr_i[31:25];

	assign imm_i = {{21{instr_i[31]}}, instr_i[30:20]};
	assign imm_s = {{21{instr_i[31]}}, instr_i[30:25], instr_i[11:7]};
	assign imm_b = {{20{instr_i[31]}}, instr_i[7], instr_i[30:25], instr_i[11:8], 1'b0};
	assign imm_u = {instr_i[31:12], 12'b0};
	assign imm_j = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

	// LUI adds its immediate to x0 through operand B
	assign rs1_addr_o    = instr_i[19:15];
	assign rs2_addr_o    = (opcode == OPC_LUI) ? '0 : instr_i[24:20];
	assign rd_addr_o     = instr_i[11:7];
	assign csr_addr_o    = instr_i[31:20];
	assign mem_size_o    = mem_size_e'(funct3[1:0]);
	assign load_signed_o = !funct3[2];

	always_comb
	begin
		rf_we_o    = 1'b0;
		wb_sel_o   = WB_ALU;
		alu_op_o   = ALU_ADD;
		op_a_sel_o = OPA_REG;
		op_b_sel_o = OPB_IMM;
		imm_o      = imm_i;
		load_o     = 1'b0;
		store_o    = 1'b0;
		csr_op_o   = CSR_NONE;
		jump_o     = 1'b0;
		branch_o   = 1'b0;
		ecall_o    = 1'b0;
		ebreak_o   = 1'b0;
		mret_o     = 1'b0;
		illegal_o  = 1'b0;

		case (opcode)
			OPC_LUI:
			begin
				rf_we_o    = 1'b1;
				op_a_sel_o = OPA_IMM;
				op_b_sel_o = OPB_REG;
				imm_o      = imm_u;
			end
			OPC_AUIPC:
			begin
				rf_we_o    = 1'b1;
				op_a_sel_o = OPA_PC;
				imm_o      = imm_u;
			end
			OPC_JAL:
			begin
				rf_we_o    = 1'b1;
				jump_o     = 1'b1;
				wb_sel_o   = WB_PC4;
				op_a_sel_o = OPA_PC;
				imm_o      = imm_j;
			end
			OPC_JALR:
			begin
				rf_we_o   = 1'b1;
				jump_o    = 1'b1;
				wb_sel_o  = WB_PC4;
				illegal_o = funct3 != 3'b000;
			end
			OPC_BRANCH:
			begin
				branch_o   = 1'b1;
				op_b_sel_o = OPB_REG;
				imm_o      = imm_b;
				case (funct3)
					3'b000:  alu_op_o = ALU_EQ;
					3'b001:  alu_op_o = ALU_NE;
					3'b100:  alu_op_o = ALU_SLT;
					3'b101:  alu_op_o = ALU_GE;
					3'b110:  alu_op_o = ALU_SLTU;
					3'b111:  alu_op_o = ALU_GEU;
					default: illegal_o = 1'b1;
				endcase
			end
			OPC_LOAD:
			begin
				rf_we_o   = 1'b1;
				wb_sel_o  = WB_LSU;
				illegal_o = funct3 == 3'b011 || funct3[2:1] == 2'b11;
				// No memory request for an illegal encoding
				load_o    = !illegal_o;
			end
			OPC_STORE:
			begin
				imm_o     = imm_s;
				illegal_o = funct3[2] || funct3[1:0] == 2'b11;
				store_o   = !illegal_o;
			end
			OPC_OP_IMM:
			begin
				rf_we_o  = 1'b1;
				alu_op_o = arith_op(funct3, funct3 == 3'b101 && instr_i[30]);
				if (funct3 == 3'b001)
					illegal_o = funct7 != 7'b0;
				else if (funct3 == 3'b101)
					illegal_o = funct7 != 7'b0 && funct7 != 7'b0100000;
			end
			OPC_OP:
			begin
				rf_we_o    = 1'b1;
				op_b_sel_o = OPB_REG;
				alu_op_o   = arith_op(funct3, instr_i[30]);
				if (funct7 == 7'b0100000)
					illegal_o = funct3 != 3'b000 && funct3 != 3'b101;
				else
					illegal_o = funct7 != 7'b0;
			end
			// FENCE retires without effect
			OPC_FENCE: illegal_o = funct3 != 3'b000;
			OPC_SYSTEM:
			begin
				if (funct3 == 3'b001 || funct3 == 3'b010)
				begin
					rf_we_o   = 1'b1;
					wb_sel_o  = WB_CSR;
					csr_op_o  = funct3[1] ? CSR_SET : CSR_WRITE;
					illegal_o = csr_addr_o != CSR_MTVEC && csr_addr_o != CSR_MEPC &&
						csr_addr_o != CSR_MCAUSE;
				end
				else
				begin
					ecall_o   = instr_i == INSTR_ECALL;
					ebreak_o  = instr_i == INSTR_EBREAK;
					mret_o    = instr_i == INSTR_MRET;
					illegal_o = !(ecall_o || ebreak_o || mret_o);
				end
			end
			default: illegal_o = 1'b1;
		endcase
	end

endmodule

//--- hw/fetch_stage.sv
module fetch_stage #(
	parameter riscv_pkg::addr_t BOOT_ADDR = 32'h0000_0000
) (
	input  logic             clk,
	input  logic             reset_i,
	input  logic             retire_i,
	input  logic             target_valid_i,
	input  riscv_pkg::addr_t target_addr_i,
	output riscv_pkg::word_t instr_o,
	output riscv_pkg::addr_t instr_addr_o,
	output logic             instr_valid_o,
	output logic             imem_valid_o,
	input  logic             imem_ready_i,
	output riscv_pkg::addr_t imem_addr_o,
	input  riscv_pkg::word_t imem_rdata_i
);

	import riscv_pkg::*;

	typedef enum logic [1:0] {F_IDLE, F_REQ, F_HOLD} fetch_state_e;

	fetch_state_e state_q;
	addr_t        pc_q;
	word_t        instr_q;

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			state_q <= F_IDLE;
			pc_q    <= BOOT_ADDR;
		end
		else
		begin
			case (state_q)
				F_IDLE: state_q <= F_REQ;
				F_REQ:
					if (imem_ready_i)
						state_q <= F_HOLD;
				F_HOLD:
					if (retire_i)
					begin
						state_q <= F_REQ;
						pc_q    <= target_valid_i ? target_addr_i : pc_q + 32'd4;
					end
				default: state_q <= F_IDLE;
			endcase
		end
	end

	// Instruction register
	always_ff @(posedge clk)
	begin
		if (state_q == F_REQ && imem_ready_i)
			instr_q <= imem_rdata_i;
	end

	assign imem_valid_o  = state_q == F_REQ;
	assign imem_addr_o   = pc_q;
	assign instr_o       = instr_q;
	assign instr_addr_o  = pc_q;
	assign instr_valid_o = state_q == F_HOLD;

	imem_stable: assert property (@(posedge clk) disable iff (reset_i)
		imem_valid_o && !imem_ready_i |=> imem_valid_o && $stable(imem_addr_o));

endmodule

//--- hw/reg_file.sv
module reg_file (
	input  logic                 clk,
	input  logic                 reset_i,
	input  logic                 write_en_i,
	input  riscv_pkg::reg_addr_t write_addr_i,
	input  riscv_pkg::word_t     write_data_i,
	input  riscv_pkg::reg_addr_t read_addr_1_i,
	input  riscv_pkg::reg_addr_t read_addr_2_i,
	output riscv_pkg::word_t     read_data_1_o,
	output riscv_pkg::word_t     read_data_2_o
);

	import riscv_pkg::*;

	word_t regs [32];

	always_ff @(posedge clk)
	begin
		if (reset_i)
		begin
			for (int i = 0; i < 32; i++)
				regs[i] <= '0;
		end
		else if (write_en_i && write_addr_i != '0)
		begin
			regs[write_addr_i] <= write_data_i;
		end
	end

	assign read_data_1_o = regs[read_addr_1_i];
	assign read_data_2_o = regs[read_addr_2_i];

	// x0 reads zero on both ports
	x0_zero_1: assert property (@(posedge clk) disable iff (reset_i)
		read_addr_1_i == '0 |-> read_data_1_o == '0);
	x0_zero_2: assert property (@(posedge clk) disable iff (reset_i)
		read_addr_2_i == '0 |-> read_data_2_o == '0);

endmodule

//--- hw/alu.sv
module alu (
	input  riscv_pkg::alu_op_e alu_op_i,
	input  riscv_pkg::word_t   operand_a_i,
	input  riscv_pkg::word_t   operand_b_i,
	output riscv_pkg::word_t   alu_result_o
);

	import riscv_pkg::*;

	logic [4:0] shamt;

	assign shamt = operand_b_i[4:0];

	always_comb
	begin
		case (alu_op_i)
			ALU_ADD:  alu_result_o = operand_a_i + operand_b_i;
			ALU_SUB:  alu_result_o = operand_a_i - operand_b_i;
			ALU_SLL:  alu_result_o = operand_a_i << shamt;
			ALU_SRL:  alu_result_o = operand_a_i >> shamt;
			ALU_SRA:  alu_result_o = word_t'($signed(operand_a_i) >>> shamt);
			ALU_XOR:  alu_result_o = operand_a_i ^ operand_b_i;
			ALU_OR:   alu_result_o = operand_a_i | operand_b_i;
			ALU_AND:  alu_result_o = operand_a_i & operand_b_i;
			ALU_SLT:  alu_result_o = {31'b0, $signed(operand_a_i) < $signed(operand_b_i)};
			ALU_SLTU: alu_result_o = {31'b0, operand_a_i < operand_b_i};
			ALU_EQ:   alu_result_o = {31'b0, operand_a_i == operand_b_i};
			ALU_NE:   alu_result_o = {31'b0, operand_a_i != operand_b_i};
			ALU_GE:   alu_result_o = {31'b0, $signed(operand_a_i) >= $signed(operand_b_i)};
			ALU_GEU:  alu_result_o = {31'b0, operand_a_i >= operand_b_i};
			default:  alu_result_o = '0;
		endcase
	end

endmodule

//--- hw/riscv_pkg.sv
package riscv_pkg;

	typedef logic [31:0] word_t;
	typedef logic [31:0] addr_t;
	typedef logic [4:0]  reg_addr_t;
	typedef logic [11:0] csr_addr_t;

	// Compare ops leave their result in bit 0
	typedef enum logic [3:0] {
		ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR, ALU_SRL,
		ALU_SRA, ALU_OR, ALU_AND, ALU_EQ, ALU_NE, ALU_GE, ALU_GEU
	} alu_op_e;

	typedef enum logic [1:0] {OPA_REG, OPA_IMM, OPA_PC} op_a_sel_e;
	typedef enum logic {OPB_REG, OPB_IMM} op_b_sel_e;
	typedef enum logic [1:0] {WB_ALU, WB_LSU, WB_CSR, WB_PC4} wb_sel_e;
	typedef enum logic [1:0] {PC_BRANCH, PC_TRAP, PC_MEPC} pc_sel_e;
	typedef enum logic [1:0] {MEM_BYTE, MEM_HALF, MEM_WORD} mem_size_e;
	typedef enum logic [1:0] {CSR_NONE, CSR_WRITE, CSR_SET} csr_op_e;

	// Machine cause codes
	localparam word_t CAUSE_ILLEGAL        = 32'd2;
	localparam word_t CAUSE_BREAK          = 32'd3;
	localparam word_t CAUSE_LOAD_MISALIGN  = 32'd4;
	localparam word_t CAUSE_STORE_MISALIGN = 32'd6;
	localparam word_t CAUSE_ECALL          = 32'd11;

	localparam logic [6:0] OPC_LUI    = 7'b0110111;
	localparam logic [6:0] OPC_AUIPC  = 7'b0010111;
	localparam logic [6:0] OPC_JAL    = 7'b1101111;
	localparam logic [6:0] OPC_JALR   = 7'b1100111;
	localparam logic [6:0] OPC_BRANCH = 7'b1100011;
	localparam logic [6:0] OPC_LOAD   = 7'b0000011;
	localparam logic [6:0] OPC_STORE  = 7'b0100011;
	localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
	localparam logic [6:0] OPC_OP     = 7'b0110011;
	localparam logic [6:0] OPC_FENCE  = 7'b0001111;
	localparam logic [6:0] OPC_SYSTEM = 7'b1110011;

	localparam csr_addr_t CSR_MTVEC  = 12'h305;
	localparam csr_addr_t CSR_MEPC   = 12'h341;
	localparam csr_addr_t CSR_MCAUSE = 12'h342;

	// Full encodings of the privileged instructions
	localparam word_t INSTR_ECALL  = 32'h0000_0073;
	localparam word_t INSTR_EBREAK = 32'h0010_0073;
	localparam word_t INSTR_MRET   = 32'h3020_0073;

endpackage
